// ==== src/axi_rd_consts.svh ====
/*
  Width and limit constants for the AXI4 read master.
  Include in any file that sizes a port, counter or memory.
*/
`ifndef AXI_RD_CONSTS_SVH
`define AXI_RD_CONSTS_SVH

// Bus widths
`define AXI_RD_ADDR_WIDTH 32
`define AXI_RD_DATA_WIDTH 32
`define AXI_RD_XFER_SIZE_WIDTH 20
`define AXI_RD_DW_BYTES 4

// Burst limits, 256 beats is below the 4 KB boundary at 4 bytes per beat
`define AXI_RD_BURST_BEATS 256
`define AXI_RD_BURST_BYTES (`AXI_RD_BURST_BEATS * `AXI_RD_DW_BYTES)

// Beat count minus one, split into full bursts and final length
`define AXI_RD_BEAT_CNT_WIDTH 18
`define AXI_RD_BURST_CNT_WIDTH 10

// Outstanding limit and FIFO sized to hold that many full bursts
`define AXI_RD_MAX_OUTSTANDING 4
`define AXI_RD_FIFO_DEPTH 1024

`endif

// ==== src/axi_rd_pkg.sv ====
/*
  Shared types for the AXI4 read master.
  Modules import this package in their header.
*/
`include "axi_rd_consts.svh"

package axi_rd_pkg;

  // Byte address and one data beat
  typedef logic [`AXI_RD_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_RD_DATA_WIDTH-1:0] data_t;

  // Beats in a burst minus one, as carried on arlen
  typedef logic [7:0] burst_len_t;

  // Split view, full bursts on top and last burst length below
  typedef struct packed {
    logic [`AXI_RD_BURST_CNT_WIDTH-1:0] bursts;
    burst_len_t                         final_len;
  } beat_split_t;

  // Total beats minus one, written raw and read split
  typedef union packed {
    logic [`AXI_RD_BEAT_CNT_WIDTH-1:0] raw;
    beat_split_t                       split;
  } beat_count_u;

endpackage

// ==== src/rd_request_decode.sv ====
/*
  Captures a start request and turns the byte size into a burst plan.
  The go strobe follows ctrl_start by two cycles, outputs hold until the next start.
*/
`timescale 1ns/1ns
`include "axi_rd_consts.svh"

module rd_request_decode import axi_rd_pkg::*; (
  input  logic                               aclk,
  input  logic                               areset,
  input  logic                               ctrl_start,
  input  addr_t                              ctrl_addr_offset,
  input  logic [`AXI_RD_XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  output logic                               go,
  output addr_t                              base_addr,
  output logic [`AXI_RD_BURST_CNT_WIDTH-1:0] burst_count,
  output burst_len_t                         final_len
);

  logic                               start_d1;
  logic [`AXI_RD_XFER_SIZE_WIDTH-1:0] size_m1;
  beat_count_u                        beat_cnt;

  // Rounded-up beats minus one is simply (size - 1) / bytes per beat
  assign size_m1 = ctrl_xfer_size_in_bytes - 1'b1;

  // Request payload, held until the next start
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Force the start down to a burst boundary
      base_addr    <= ctrl_addr_offset & ~addr_t'(`AXI_RD_BURST_BYTES - 1);
      beat_cnt.raw <= size_m1[`AXI_RD_XFER_SIZE_WIDTH-1:$clog2(`AXI_RD_DW_BYTES)];
    end
  end

  // Two-stage strobe delay gives the decode a fixed latency
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      go       <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      go       <= start_d1;
    end
  end

  // Zero full bursts means one burst carrying final_len
  assign burst_count = beat_cnt.split.bursts;
  assign final_len   = beat_cnt.split.final_len;

  // A zero-byte request has no meaning here
  a_size_nonzero: assert property (@(posedge aclk) disable iff (areset)
    ctrl_start |-> ctrl_xfer_size_in_bytes != '0);

  // No second start while the first is still being decoded
  a_no_restart: assert property (@(posedge aclk) disable iff (areset)
    ctrl_start |=> !ctrl_start [*2]);

endmodule

// ==== src/ar_issue.sv ====
/*
  Read address channel driver.
  Walks the burst plan from decode, one address per burst, and stalls
  once the outstanding limit is used up until result retires a burst.
*/
`timescale 1ns/1ns
`include "axi_rd_consts.svh"

module ar_issue import axi_rd_pkg::*; (
  input  logic                               aclk,
  input  logic                               areset,
  input  logic                               go,
  input  addr_t                              base_addr,
  input  logic [`AXI_RD_BURST_CNT_WIDTH-1:0] burst_count,
  input  burst_len_t                         final_len,
  input  logic                               m_axi_arready,
  input  logic                               burst_retired,
  output logic                               m_axi_arvalid,
  output addr_t                              m_axi_araddr,
  output burst_len_t                         m_axi_arlen
);

  localparam int CREDIT_W = $clog2(`AXI_RD_MAX_OUTSTANDING + 1);

  logic                               idle;
  logic                               arxfer;
  logic                               final_burst;
  logic                               have_credit;
  logic [`AXI_RD_BURST_CNT_WIDTH-1:0] bursts_left;
  logic [CREDIT_W-1:0]                credits;

  assign arxfer      = m_axi_arvalid & m_axi_arready;
  assign final_burst = (bursts_left == '0);
  assign have_credit = (credits != '0);

  // Full bursts use the max length, the last one its remainder
  assign m_axi_arlen = final_burst ? final_len : burst_len_t'(`AXI_RD_BURST_BEATS - 1);

  //////////////////////////////
  // Address channel control
  //////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      idle          <= 1'b1;
      m_axi_arvalid <= 1'b0;
    end else begin
      if (go) begin
        idle <= 1'b0;
      end else if (arxfer && final_burst) begin
        idle <= 1'b1;
      end
      // Raise on go or after a transfer, drop once accepted
      if (m_axi_arvalid) begin
        m_axi_arvalid <= ~m_axi_arready;
      end else begin
        m_axi_arvalid <= (go | ~idle) & have_credit;
      end
    end
  end

  // Burst counter and address, advanced per accepted address
  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (go) begin
      bursts_left <= burst_count;
    end else if (arxfer && !final_burst) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (go) begin
      m_axi_araddr <= base_addr;
    end else if (arxfer) begin
      m_axi_araddr <= m_axi_araddr + addr_t'(`AXI_RD_BURST_BYTES);
    end
  end

  // Free outstanding slots, taken per address and returned per retired burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      credits <= CREDIT_W'(`AXI_RD_MAX_OUTSTANDING);
    end else begin
      credits <= credits + CREDIT_W'(burst_retired) - CREDIT_W'(arxfer);
    end
  end

  // Address and length hold while the slave stalls
  a_ar_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen));

  // Result never retires more bursts than were issued
  a_credit_max: assert property (@(posedge aclk) disable iff (areset)
    credits <= CREDIT_W'(`AXI_RD_MAX_OUTSTANDING));

endmodule

// ==== src/r_stream_fifo.sv ====
/*
  First-word-fall-through FIFO for read beats and their last flag.
  A written entry shows at the head one cycle later.
*/
`timescale 1ns/1ns
`include "axi_rd_consts.svh"

module r_stream_fifo import axi_rd_pkg::*; (
  input  logic  aclk,
  input  logic  areset,
  input  logic  wr_en,
  input  data_t wr_data,
  input  logic  wr_last,
  input  logic  rd_ready,
  output logic  rd_valid,
  output data_t rd_data,
  output logic  rd_last
);

  localparam int PTR_W = $clog2(`AXI_RD_FIFO_DEPTH);

  // Each entry is the last flag on top of the data word
  logic [`AXI_RD_DATA_WIDTH:0] mem [`AXI_RD_FIFO_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [PTR_W:0]              count;
  logic                        rd_en;

  assign rd_valid = (count != '0);
  assign rd_en    = rd_valid & rd_ready;

  // Head entry straight from the array
  assign {rd_last, rd_data} = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {wr_last, wr_data};
    end
  end

  // Pointers wrap naturally on a power-of-two depth
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (PTR_W+1)'(wr_en) - (PTR_W+1)'(rd_en);
    end
  end

  // The outstanding limit upstream must keep the FIFO from filling
  a_no_overflow: assert property (@(posedge aclk) disable iff (areset)
    wr_en |-> count < (PTR_W+1)'(`AXI_RD_FIFO_DEPTH));

endmodule

// ==== src/r_result.sv ====
/*
  Read data side. Every R beat goes into the stream FIFO, the final
  burst's last beat raises ctrl_done, and each tlast leaving the
  stream returns one outstanding credit to the address side.
*/
`timescale 1ns/1ns
`include "axi_rd_consts.svh"

module r_result import axi_rd_pkg::*; (
  input  logic                               aclk,
  input  logic                               areset,
  input  logic                               go,
  input  logic [`AXI_RD_BURST_CNT_WIDTH-1:0] burst_count,
  input  logic                               m_axi_rvalid,
  input  data_t                              m_axi_rdata,
  input  logic                               m_axi_rlast,
  input  logic                               m_axis_tready,
  output logic                               m_axi_rready,
  output logic                               m_axis_tvalid,
  output data_t                              m_axis_tdata,
  output logic                               m_axis_tlast,
  output logic                               burst_retired,
  output logic                               ctrl_done
);

  logic                               rxfer;
  logic                               burst_end;
  logic [`AXI_RD_BURST_CNT_WIDTH-1:0] bursts_left;

  // FIFO covers every outstanding burst, so reads never stall
  assign m_axi_rready = 1'b1;
  assign rxfer        = m_axi_rvalid & m_axi_rready;
  assign burst_end    = rxfer & m_axi_rlast;

  r_stream_fifo i_r_stream_fifo (
    .aclk     (aclk),
    .areset   (areset),
    .wr_en    (rxfer),
    .wr_data  (m_axi_rdata),
    .wr_last  (m_axi_rlast),
    .rd_ready (m_axis_tready),
    .rd_valid (m_axis_tvalid),
    .rd_data  (m_axis_tdata),
    .rd_last  (m_axis_tlast)
  );

  // Bursts still due on the read channel
  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (go) begin
      bursts_left <= burst_count;
    end else if (burst_end && bursts_left != '0) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  // Done one cycle after the final rlast even with queued data left
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= burst_end & (bursts_left == '0);
    end
  end

  // A tlast leaving the stream frees one outstanding slot
  assign burst_retired = m_axis_tvalid & m_axis_tready & m_axis_tlast;

endmodule

// ==== src/axi_read_master.sv ====
/*
  AXI4 read master with a stream output.
  Pulse ctrl_start with an address and byte size; data leaves on m_axis
  and ctrl_done pulses after the last read beat has been taken.
*/
`timescale 1ns/1ns
`include "axi_rd_consts.svh"

module axi_read_master import axi_rd_pkg::*; (
  input  logic                               aclk,
  input  logic                               areset,
  // Control
  input  logic                               ctrl_start,
  input  addr_t                              ctrl_addr_offset,
  input  logic [`AXI_RD_XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  output logic                               ctrl_done,
  // AXI4 read address and data channels
  output logic                               m_axi_arvalid,
  input  logic                               m_axi_arready,
  output addr_t                              m_axi_araddr,
  output burst_len_t                         m_axi_arlen,
  input  logic                               m_axi_rvalid,
  output logic                               m_axi_rready,
  input  data_t                              m_axi_rdata,
  input  logic                               m_axi_rlast,
  // AXI4-Stream output
  output logic                               m_axis_tvalid,
  input  logic                               m_axis_tready,
  output data_t                              m_axis_tdata,
  output logic                               m_axis_tlast
);

  logic                               go;
  addr_t                              base_addr;
  logic [`AXI_RD_BURST_CNT_WIDTH-1:0] burst_count;
  burst_len_t                         final_len;
  logic                               burst_retired;

  rd_request_decode i_rd_request_decode (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .go                      (go),
    .base_addr               (base_addr),
    .burst_count             (burst_count),
    .final_len               (final_len)
  );

  ar_issue i_ar_issue (
    .aclk          (aclk),
    .areset        (areset),
    .go            (go),
    .base_addr     (base_addr),
    .burst_count   (burst_count),
    .final_len     (final_len),
    .m_axi_arready (m_axi_arready),
    .burst_retired (burst_retired),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  r_result i_r_result (
    .aclk          (aclk),
    .areset        (areset),
    .go            (go),
    .burst_count   (burst_count),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rlast   (m_axi_rlast),
    .m_axis_tready (m_axis_tready),
    .m_axi_rready  (m_axi_rready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .burst_retired (burst_retired),
    .ctrl_done     (ctrl_done)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
  Free-running clock for the testbench.
  The period is set by parameter, the first rising edge comes at half a period.
*/
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic aclk
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

endmodule

// ==== testbench/axi_mem_model.sv ====
/*
  AXI4 read slave model for the testbench.
  Queues every accepted burst and returns its beats in order, each carrying
  its own byte address as data. Ready and valid gaps come from rand_word.
*/
`timescale 1ns/1ns

module axi_mem_model (
  input  logic        aclk,
  input  logic        areset,
  input  logic [31:0] rand_word,
  input  logic        m_axi_arvalid,
  output logic        m_axi_arready,
  input  logic [31:0] m_axi_araddr,
  input  logic [7:0]  m_axi_arlen,
  output logic        m_axi_rvalid,
  input  logic        m_axi_rready,
  output logic [31:0] m_axi_rdata,
  output logic        m_axi_rlast
);

  // Accepted bursts as {arlen, araddr}, head is the one being returned
  logic [39:0] bursts [$];
  logic [39:0] head;
  logic [7:0]  beat_idx;
  logic [31:0] gaps;
  logic        r_taken;

  initial begin
    m_axi_arready = 1'b0;
    m_axi_rvalid  = 1'b0;
    m_axi_rdata   = '0;
    m_axi_rlast   = 1'b0;
    beat_idx      = '0;
    forever begin
      @(posedge aclk);
      // Handshakes seen with the values from before the edge
      gaps    = rand_word;
      r_taken = m_axi_rvalid && m_axi_rready;
      if (areset) begin
        bursts.delete();
        beat_idx = '0;
      end else begin
        if (m_axi_arvalid && m_axi_arready) begin
          bursts.push_back({m_axi_arlen, m_axi_araddr});
        end
        if (r_taken && m_axi_rlast) begin
          bursts.delete(0);
          beat_idx = '0;
        end else if (r_taken) begin
          beat_idx = beat_idx + 8'd1;
        end
      end
      #10;
      // Address ready about three cycles in four
      m_axi_arready = !areset && (gaps[31:30] != 2'b00);
      // A beat not yet taken stays on the bus
      if (!m_axi_rvalid || r_taken) begin
        m_axi_rvalid = (bursts.size() != 0) && (gaps[29:27] != 3'b000);
        if (bursts.size() != 0) begin
          head        = bursts[0];
          m_axi_rdata = head[31:0] + {22'd0, beat_idx, 2'b00};
          m_axi_rlast = (beat_idx == head[39:32]);
        end
      end
    end
  end

endmodule

// ==== testbench/axi_read_master_tb.sv ====
/*
  Testbench for the AXI4 read master.
  Eight random requests run against a slave model with random gaps while
  assertions check bursts, stream data, the outstanding limit and ctrl_done.
*/
`timescale 1ns/1ns

module axi_read_master_tb;

  localparam logic [31:0] SEED    = 32'h1745_ccf4;
  localparam int unsigned NUM_REQ = 8;
  localparam int unsigned TIMEOUT = 20000;

  logic        aclk;
  logic        areset;
  logic        ctrl_start;
  logic [31:0] ctrl_addr_offset;
  logic [19:0] ctrl_xfer_size_in_bytes;
  logic        ctrl_done;
  logic        m_axi_arvalid;
  logic        m_axi_arready;
  logic [31:0] m_axi_araddr;
  logic [7:0]  m_axi_arlen;
  logic        m_axi_rvalid;
  logic        m_axi_rready;
  logic [31:0] m_axi_rdata;
  logic        m_axi_rlast;
  logic        m_axis_tvalid;
  logic        m_axis_tready;
  logic [31:0] m_axis_tdata;
  logic        m_axis_tlast;

  logic [31:0] rand_word;
  logic [31:0] req_state;
  logic [31:0] gap_state;
  int unsigned stall_left;
  // Expected bursts as {arlen, araddr} and beats as {tlast, tdata}
  logic [39:0] exp_ar [$];
  logic [32:0] exp_beats [$];
  int          outstanding;
  int unsigned rlast_total;
  int unsigned rlast_target;
  int unsigned done_count;
  logic        final_rlast_xfer;

  tb_clock_gen #(.PERIOD_NS(100)) i_tb_clock_gen (.aclk(aclk));

  axi_mem_model i_axi_mem_model (
    .aclk(aclk), .areset(areset), .rand_word(rand_word),
    .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
    .m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen),
    .m_axi_rvalid(m_axi_rvalid), .m_axi_rready(m_axi_rready),
    .m_axi_rdata(m_axi_rdata), .m_axi_rlast(m_axi_rlast)
  );

  axi_read_master i_axi_read_master (
    .aclk(aclk), .areset(areset), .ctrl_start(ctrl_start),
    .ctrl_addr_offset(ctrl_addr_offset), .ctrl_xfer_size_in_bytes(ctrl_xfer_size_in_bytes),
    .ctrl_done(ctrl_done), .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
    .m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen), .m_axi_rvalid(m_axi_rvalid),
    .m_axi_rready(m_axi_rready), .m_axi_rdata(m_axi_rdata), .m_axi_rlast(m_axi_rlast),
    .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
    .m_axis_tdata(m_axis_tdata), .m_axis_tlast(m_axis_tlast)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "testbench check");
  endtask

  task automatic report_stall(input string msg);
    $display("Timeout: %s", msg);
    $display("TB FAILED");
    $fatal(1, "testbench timeout");
  endtask

  //////////////////////////////
  // Request side
  //////////////////////////////

  // Expected bursts and beats follow from size and offset alone
  task automatic start_request(input logic [31:0] offset, input int unsigned size);
    logic [31:0] base;
    logic [7:0]  len;
    logic        last;
    int unsigned beats;
    int unsigned nbursts;
    int unsigned k;
    base    = offset & 32'hffff_fc00;
    beats   = (size + 3) / 4;
    nbursts = (beats + 255) / 256;
    for (k = 0; k < nbursts; k++) begin
      len = (k == nbursts - 1) ? 8'((beats - 1) % 256) : 8'd255;
      exp_ar.push_back({len, base + k * 1024});
    end
    for (k = 0; k < beats; k++) begin
      last = (k % 256 == 255) || (k == beats - 1);
      exp_beats.push_back({last, base + k * 4});
    end
    rlast_target            = rlast_total + nbursts;
    ctrl_addr_offset        = offset;
    ctrl_xfer_size_in_bytes = 20'(size);
    ctrl_start              = 1'b1;
    @(posedge aclk);
    #10;
    ctrl_start = 1'b0;
  endtask

  task automatic wait_done(input int unsigned expected);
    int unsigned cycles;
    cycles = 0;
    while (done_count != expected && cycles < TIMEOUT) begin
      @(posedge aclk);
      #10;
      cycles++;
    end
    if (done_count != expected) begin
      report_stall("ctrl_done never came for the current request");
    end
    // All bursts of the request must have been issued by now
    assert (exp_ar.size() == 0)
      else report_mismatch($sformatf("%0d bursts never issued", exp_ar.size()));
  endtask

  task automatic wait_drain();
    int unsigned cycles;
    cycles = 0;
    while (exp_beats.size() != 0 && cycles < TIMEOUT) begin
      @(posedge aclk);
      #10;
      cycles++;
    end
    if (exp_beats.size() != 0) begin
      report_stall("stream stopped before all expected beats came out");
    end
  endtask

  initial begin
    int unsigned req;
    int unsigned size;
    logic [31:0] offset;
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    req_state               = SEED;
    rlast_target            = 0;
    repeat (10) @(posedge aclk);
    #10;
    areset = 1'b0;
    for (req = 0; req < NUM_REQ; req++) begin
      req_state = lcg_step(req_state);
      offset    = req_state;
      req_state = lcg_step(req_state);
      // First request is always four bursts, so the limit gets hit
      if (req == 0) begin
        size = 3073 + 32'(req_state[31:12]) % 928;
      end else begin
        size = 1 + 32'(req_state[31:12]) % 4000;
      end
      start_request(offset, size);
      wait_done(req + 1);
    end
    wait_drain();
    // Nothing may stay queued once every expected beat has left
    if (done_count == NUM_REQ && exp_ar.size() == 0 && outstanding == 0 && !m_axis_tvalid) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_mismatch("requests, bursts or stream beats left over at end of run");
    end
  end

  // Random gaps for the model and back-pressure windows on the stream
  initial begin
    gap_state     = ~SEED;
    rand_word     = '0;
    m_axis_tready = 1'b0;
    // Stream held off until the second request finds every slot taken
    stall_left    = 2000;
    forever begin
      @(posedge aclk);
      #10;
      gap_state = lcg_step(gap_state);
      rand_word = gap_state;
      if (stall_left != 0) begin
        stall_left    = stall_left - 1;
        m_axis_tready = 1'b0;
      end else if (gap_state[15:7] == '0) begin
        stall_left    = 100 + 32'(gap_state[24:16]);
        m_axis_tready = 1'b0;
      end else begin
        m_axis_tready = (gap_state[26:25] != 2'b00);
      end
    end
  end

  //////////////////////////////
  // Scoreboard
  //////////////////////////////

  task automatic check_address();
    logic [39:0] exp;
    assert (exp_ar.size() != 0)
      else report_mismatch($sformatf("unexpected read address %h", m_axi_araddr));
    exp = exp_ar.pop_front();
    assert (m_axi_araddr == exp[31:0] && m_axi_arlen == exp[39:32])
      else report_mismatch($sformatf("araddr %h arlen %0d, expected %h arlen %0d",
        m_axi_araddr, m_axi_arlen, exp[31:0], exp[39:32]));
  endtask

  task automatic check_beat();
    logic [32:0] exp;
    assert (exp_beats.size() != 0)
      else report_mismatch($sformatf("unexpected stream beat %h", m_axis_tdata));
    exp = exp_beats.pop_front();
    assert (m_axis_tdata == exp[31:0] && m_axis_tlast == exp[32])
      else report_mismatch($sformatf("tdata %h tlast %b, expected %h tlast %b",
        m_axis_tdata, m_axis_tlast, exp[31:0], exp[32]));
  endtask

  // Last read beat of the final burst of the running request
  assign final_rlast_xfer = m_axi_rvalid && m_axi_rready && m_axi_rlast
                            && (rlast_total + 1 == rlast_target);

  always @(posedge aclk) begin
    if (areset) begin
      outstanding <= 0;
      rlast_total <= 0;
      done_count  <= 0;
    end else begin
      if (m_axi_arvalid && m_axi_arready) begin
        check_address();
      end
      if (m_axis_tvalid && m_axis_tready) begin
        check_beat();
      end
      outstanding <= outstanding + ((m_axi_arvalid && m_axi_arready) ? 1 : 0)
                     - ((m_axis_tvalid && m_axis_tready && m_axis_tlast) ? 1 : 0);
      if (m_axi_rvalid && m_axi_rready && m_axi_rlast) begin
        rlast_total <= rlast_total + 1;
      end
      if (ctrl_done) begin
        done_count <= done_count + 1;
      end
    end
  end

  //////////////////////////////
  // Protocol checks
  //////////////////////////////

  a_reset_idle: assert property (@(posedge aclk)
    areset |=> !m_axi_arvalid && !m_axis_tvalid && !ctrl_done && m_axi_rready)
    else report_mismatch("outputs not idle during reset");

  a_outstanding_max: assert property (@(posedge aclk) disable iff (areset)
    outstanding <= 4)
    else report_mismatch($sformatf("%0d bursts outstanding", outstanding));

  a_arvalid_slot: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid |-> outstanding < 4)
    else report_mismatch("arvalid high with four bursts outstanding");

  // Full limit keeps the address channel quiet until a burst retires
  a_full_holds_ar: assert property (@(posedge aclk) disable iff (areset)
    outstanding == 4 && !m_axi_arvalid |=> !m_axi_arvalid)
    else report_mismatch("arvalid rose with four bursts outstanding");

  a_done_single: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else report_mismatch("ctrl_done high for two cycles");

  a_done_after_last: assert property (@(posedge aclk) disable iff (areset)
    final_rlast_xfer |=> ctrl_done)
    else report_mismatch("ctrl_done missing after final read beat");

  a_done_only_last: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |-> $past(final_rlast_xfer))
    else report_mismatch("ctrl_done without a final read beat");

endmodule

// ==== files.f ====
+incdir+src
src/axi_rd_pkg.sv
src/rd_request_decode.sv
src/ar_issue.sv
src/r_stream_fifo.sv
src/r_result.sv
src/axi_read_master.sv
testbench/tb_clock_gen.sv
testbench/axi_mem_model.sv
testbench/axi_read_master_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vaxi_read_master_tb
SRCS := $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module axi_read_master_tb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
